/* project.f */
+incdir+rtl
rtl/dsp_pkg.sv
rtl/detector_pkg.sv
rtl/pss_correlator.sv
rtl/energy_window.sv
rtl/nid2_decider.sv
rtl/pss_detector.sv
test/tb_clock_gen.sv
test/tb_pss_detector.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    -f project.f --top-module tb_pss_detector -o sim_pss_detector \
    && ./obj_dir/sim_pss_detector | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* test/tb_pss_detector.sv */
`timescale 1ns/1ps

`include "pss_params.svh"

module tb_pss_detector;

    localparam int NUM_TESTS        = 6;
    localparam int MAX_TEST_SAMPLES = 200;
    // six tests of up to 200 samples three times over and rounded up to a thousand
    localparam int TIMEOUT_CYCLES = ((NUM_TESTS * MAX_TEST_SAMPLES * 3 + 999) / 1000) * 1000;
    localparam int AMPLITUDE = 1000;

    logic                 clk_i;
    logic                 reset_int_n;
    dsp_pkg::sample_u     sample_i;
    logic                 sample_valid_i;
    detector_pkg::mode_e  mode_i;
    detector_pkg::nid2_t  requested_nid2_i;
    detector_pkg::nid2_t  nid2_o;
    logic                 nid2_valid_o;
    detector_pkg::count_t peak_count_0_o;
    detector_pkg::count_t peak_count_1_o;
    detector_pkg::count_t peak_count_2_o;

    // reference model history with hist[0] as the oldest sample
    int hist_i [`PSS_LEN];
    int hist_q [`PSS_LEN];
    int strobe_count = 0;
    int model_count [3];
    // expected report for the strobes one and two steps back
    logic pipe_valid [2];
    detector_pkg::nid2_t pipe_nid2 [2];
    logic seen_valid;
    detector_pkg::nid2_t seen_nid2;
    int pulse_total = 0;
    detector_pkg::count_t count_snap [3];

    int error_count = 0;
    int checks_done = 0;
    int tests_done  = 0;
    int cycle_count = 0;
    integer seed;

    tb_clock_gen #(.PERIOD_NS(40)) clock_gen_i (.clk_o(clk_i));

    pss_detector dut_i (
        .clk_i            (clk_i),
        .reset_int_n      (reset_int_n),
        .sample_i         (sample_i),
        .sample_valid_i   (sample_valid_i),
        .mode_i           (mode_i),
        .requested_nid2_i (requested_nid2_i),
        .nid2_o           (nid2_o),
        .nid2_valid_o     (nid2_valid_o),
        .peak_count_0_o   (peak_count_0_o),
        .peak_count_1_o   (peak_count_1_o),
        .peak_count_2_o   (peak_count_2_o)
    );

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_nid2(input string name, input detector_pkg::nid2_t actual,
                              input detector_pkg::nid2_t expected);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0d ns %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input detector_pkg::count_t actual,
                               input detector_pkg::count_t expected);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0d ns %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_pulse(input string name, input logic actual, input logic expected);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0d ns %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic int tap_value(input int lane, input int k, input int amp);
        if (detector_pkg::PSS_TAPS[lane][k]) begin
            return -amp;
        end
        return amp;
    endfunction

    function automatic int abs_int(input int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic int correlation_mag(input int lane);
        int re;
        int im;
        re = 0;
        im = 0;
        for (int k = 0; k < `PSS_LEN; k++) begin
            re += tap_value(lane, k, hist_i[k]);
            im += tap_value(lane, k, hist_q[k]);
        end
        return abs_int(re) + abs_int(im);
    endfunction

    task automatic predict_report(input int i_val, input int q_val, output logic exp_valid,
                                  output detector_pkg::nid2_t exp_nid2);
        int limit;
        int mag;
        int hits;
        int hit_lane;
        limit    = 0;
        hits     = 0;
        hit_lane = 0;
        for (int k = 0; k < `PSS_LEN - 1; k++) begin
            hist_i[k] = hist_i[k+1];
            hist_q[k] = hist_q[k+1];
        end
        hist_i[`PSS_LEN-1] = i_val;
        hist_q[`PSS_LEN-1] = q_val;
        strobe_count++;
        exp_valid = 1'b0;
        exp_nid2  = '0;
        // no decision before the window is full and none at all while paused
        if (strobe_count >= `PSS_LEN && mode_i != detector_pkg::PAUSE) begin
            for (int k = 0; k < `PSS_LEN; k++) begin
                limit += abs_int(hist_i[k]) + abs_int(hist_q[k]);
            end
            limit = limit >> `DETECTION_SHIFT;
            for (int l = 0; l < 3; l++) begin
                mag = correlation_mag(l);
                if (mag > `NOISE_LIMIT && mag > limit) begin
                    model_count[l]++;
                    hits++;
                    hit_lane = l;
                end
            end
            exp_nid2 = detector_pkg::nid2_t'(hit_lane);
            if (hits == 1 && (mode_i == detector_pkg::SEARCH ||
                              (mode_i == detector_pkg::FIND && exp_nid2 == requested_nid2_i))) begin
                exp_valid = 1'b1;
            end
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    // called on a falling edge and returns on the next one
    task automatic step(input logic valid, input int i_val, input int q_val);
        logic exp_valid;
        detector_pkg::nid2_t exp_nid2;
        // what shows now belongs to the strobe two steps back
        seen_valid = nid2_valid_o;
        seen_nid2  = nid2_o;
        if (nid2_valid_o === 1'b1) begin
            pulse_total++;
        end
        check_pulse("nid2_valid_o", nid2_valid_o, pipe_valid[1]);
        if (pipe_valid[1] && nid2_valid_o === 1'b1) begin
            check_nid2("nid2_o", nid2_o, pipe_nid2[1]);
        end
        pipe_valid[1] = pipe_valid[0];
        pipe_nid2[1]  = pipe_nid2[0];
        exp_valid = 1'b0;
        exp_nid2  = '0;
        if (valid) begin
            predict_report(i_val, q_val, exp_valid, exp_nid2);
        end
        pipe_valid[0]  = exp_valid;
        pipe_nid2[0]   = exp_nid2;
        sample_valid_i = valid;
        sample_i.iq.i  = i_val[`SAMPLE_W-1:0];
        sample_i.iq.q  = q_val[`SAMPLE_W-1:0];
        @(negedge clk_i);
    endtask

    task automatic send_zeros(input int n);
        repeat (n) step(1'b1, 0, 0);
    endtask

    task automatic flush();
        repeat (3) step(1'b0, 0, 0);
    endtask

    task automatic set_mode(input detector_pkg::mode_e m, input detector_pkg::nid2_t req);
        flush();
        mode_i           = m;
        requested_nid2_i = req;
    endtask

    task automatic send_sequence(input int lane);
        for (int k = 0; k < `PSS_LEN; k++) begin
            step(1'b1, tap_value(lane, k, AMPLITUDE), tap_value(lane, k, AMPLITUDE));
        end
    endtask

    task automatic send_and_expect(input int lane, input logic expect_pulse);
        send_sequence(lane);
        // report for the last tap is seen at the start of the second step after it
        send_zeros(2);
        check_pulse("nid2_valid_o", seen_valid, expect_pulse);
        if (expect_pulse) begin
            check_nid2("nid2_o", seen_nid2, detector_pkg::nid2_t'(lane));
        end
        send_zeros(`PSS_LEN - 2);
    endtask

    task automatic check_model_counts();
        check_count("peak_count_0_o", peak_count_0_o, detector_pkg::count_t'(model_count[0]));
        check_count("peak_count_1_o", peak_count_1_o, detector_pkg::count_t'(model_count[1]));
        check_count("peak_count_2_o", peak_count_2_o, detector_pkg::count_t'(model_count[2]));
    endtask

    task automatic take_count_snapshot();
        count_snap[0] = peak_count_0_o;
        count_snap[1] = peak_count_1_o;
        count_snap[2] = peak_count_2_o;
    endtask

    task automatic check_counts_unchanged();
        check_count("peak_count_0_o", peak_count_0_o, count_snap[0]);
        check_count("peak_count_1_o", peak_count_1_o, count_snap[1]);
        check_count("peak_count_2_o", peak_count_2_o, count_snap[2]);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_done++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic warm_up_test();
        int errors_before;
        int pulses_before;
        errors_before = error_count;
        pulses_before = pulse_total;
        // taps 1 to 15 of lane 0 would fire if the window were full
        for (int k = 1; k < `PSS_LEN; k++) begin
            step(1'b1, tap_value(0, k, AMPLITUDE), tap_value(0, k, AMPLITUDE));
        end
        flush();
        checks_done++;
        if (pulse_total != pulses_before) begin
            error_count++;
            $display("warm-up: nid2_valid_o pulsed before %0d samples had arrived", `PSS_LEN);
        end
        check_model_counts();
        report_test("warm-up", errors_before);
    endtask

    task automatic search_test();
        int errors_before;
        errors_before = error_count;
        set_mode(detector_pkg::SEARCH, 2'd0);
        send_zeros(`PSS_LEN);
        for (int lane = 0; lane < 3; lane++) begin
            send_and_expect(lane, 1'b1);
        end
        flush();
        check_model_counts();
        report_test("search", errors_before);
    endtask

    task automatic find_test();
        int errors_before;
        errors_before = error_count;
        for (int lane = 0; lane < 3; lane++) begin
            set_mode(detector_pkg::FIND, detector_pkg::nid2_t'((lane + 1) % 3));
            send_and_expect(lane, 1'b0);
            set_mode(detector_pkg::FIND, detector_pkg::nid2_t'(lane));
            send_and_expect(lane, 1'b1);
        end
        flush();
        check_model_counts();
        report_test("find", errors_before);
    endtask

    task automatic pause_test();
        int errors_before;
        errors_before = error_count;
        take_count_snapshot();
        set_mode(detector_pkg::PAUSE, 2'd0);
        for (int lane = 0; lane < 3; lane++) begin
            send_and_expect(lane, 1'b0);
        end
        flush();
        check_counts_unchanged();
        check_model_counts();
        report_test("pause", errors_before);
    endtask

    task automatic noise_test();
        int errors_before;
        int pulses_before;
        int i_val;
        int q_val;
        errors_before = error_count;
        set_mode(detector_pkg::SEARCH, 2'd0);
        take_count_snapshot();
        pulses_before = pulse_total;
        repeat (MAX_TEST_SAMPLES - 40) begin
            i_val = $random(seed) % 4;
            q_val = $random(seed) % 4;
            step(1'b1, i_val, q_val);
        end
        flush();
        checks_done++;
        if (pulse_total != pulses_before) begin
            error_count++;
            $display("noise: low-level noise produced %0d reports", pulse_total - pulses_before);
        end
        check_counts_unchanged();
        check_model_counts();
        report_test("noise", errors_before);
    endtask

    task automatic counter_test();
        int errors_before;
        int v;
        errors_before = error_count;
        set_mode(detector_pkg::SEARCH, 2'd0);
        send_and_expect(2, 1'b1);
        // lanes 0 and 1 at once both fire and leave nothing to report
        for (int k = 0; k < `PSS_LEN; k++) begin
            v = tap_value(0, k, AMPLITUDE) + tap_value(1, k, AMPLITUDE);
            step(1'b1, v, v);
        end
        send_zeros(2);
        check_pulse("nid2_valid_o", seen_valid, 1'b0);
        send_zeros(`PSS_LEN - 2);
        set_mode(detector_pkg::FIND, 2'd0);
        send_and_expect(1, 1'b0);
        set_mode(detector_pkg::PAUSE, 2'd0);
        send_and_expect(0, 1'b0);
        set_mode(detector_pkg::SEARCH, 2'd0);
        send_sequence(0);
        send_sequence(2);
        send_zeros(`PSS_LEN);
        flush();
        check_model_counts();
        report_test("counters", errors_before);
    endtask

    // ----------------------------------------
    // run control
    // ----------------------------------------

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        seed             = 32'ha226_f4e4;
        reset_int_n      = 1'b0;
        sample_i.raw     = '0;
        sample_valid_i   = 1'b0;
        mode_i           = detector_pkg::SEARCH;
        requested_nid2_i = '0;
        for (int k = 0; k < `PSS_LEN; k++) begin
            hist_i[k] = 0;
            hist_q[k] = 0;
        end
        for (int l = 0; l < 3; l++) begin
            model_count[l] = 0;
        end
        pipe_valid[0] = 1'b0;
        pipe_valid[1] = 1'b0;
        pipe_nid2[0]  = '0;
        pipe_nid2[1]  = '0;

        repeat (4) @(negedge clk_i);
        reset_int_n = 1'b1;

        warm_up_test();
        search_test();
        find_test();
        pause_test();
        noise_test();
        counter_test();

        $display("done: %0d tests, %0d checks, %0d errors", tests_done, checks_done, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* rtl/pss_detector.sv */
`timescale 1ns/1ps

module pss_detector (
    input  logic                  clk_i,
    input  logic                  reset_int_n,
    input  dsp_pkg::sample_u      sample_i,
    input  logic                  sample_valid_i,
    input  detector_pkg::mode_e   mode_i,
    input  detector_pkg::nid2_t   requested_nid2_i,
    output detector_pkg::nid2_t   nid2_o,
    output logic                  nid2_valid_o,
    output detector_pkg::count_t  peak_count_0_o,
    output detector_pkg::count_t  peak_count_1_o,
    output detector_pkg::count_t  peak_count_2_o
);

    dsp_pkg::mag_t corr_mag_0;
    dsp_pkg::mag_t corr_mag_1;
    dsp_pkg::mag_t corr_mag_2;
    dsp_pkg::mag_t energy;
    logic energy_valid;

    // ----------------------------------------
    // correlators and energy, side by side
    // ----------------------------------------

    pss_correlator #(.LANE(0)) corr_0_i (
        .clk_i          (clk_i),
        .reset_int_n    (reset_int_n),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .corr_mag_o     (corr_mag_0)
    );

    pss_correlator #(.LANE(1)) corr_1_i (
        .clk_i          (clk_i),
        .reset_int_n    (reset_int_n),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .corr_mag_o     (corr_mag_1)
    );

    pss_correlator #(.LANE(2)) corr_2_i (
        .clk_i          (clk_i),
        .reset_int_n    (reset_int_n),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .corr_mag_o     (corr_mag_2)
    );

    energy_window energy_i (
        .clk_i          (clk_i),
        .reset_int_n    (reset_int_n),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .energy_o       (energy),
        .energy_valid_o (energy_valid)
    );

    nid2_decider decider_i (
        .clk_i            (clk_i),
        .reset_int_n      (reset_int_n),
        .corr_mag_0_i     (corr_mag_0),
        .corr_mag_1_i     (corr_mag_1),
        .corr_mag_2_i     (corr_mag_2),
        .energy_i         (energy),
        .energy_valid_i   (energy_valid),
        .mode_i           (mode_i),
        .requested_nid2_i (requested_nid2_i),
        .nid2_o           (nid2_o),
        .nid2_valid_o     (nid2_valid_o),
        .peak_count_0_o   (peak_count_0_o),
        .peak_count_1_o   (peak_count_1_o),
        .peak_count_2_o   (peak_count_2_o)
    );

endmodule

/* rtl/nid2_decider.sv */
`timescale 1ns/1ps

`include "pss_params.svh"

module nid2_decider (
    input  logic                  clk_i,
    input  logic                  reset_int_n,
    input  dsp_pkg::mag_t         corr_mag_0_i,
    input  dsp_pkg::mag_t         corr_mag_1_i,
    input  dsp_pkg::mag_t         corr_mag_2_i,
    input  dsp_pkg::mag_t         energy_i,
    input  logic                  energy_valid_i,
    input  detector_pkg::mode_e   mode_i,
    input  detector_pkg::nid2_t   requested_nid2_i,
    output detector_pkg::nid2_t   nid2_o,
    output logic                  nid2_valid_o,
    output detector_pkg::count_t  peak_count_0_o,
    output detector_pkg::count_t  peak_count_1_o,
    output detector_pkg::count_t  peak_count_2_o
);

    localparam dsp_pkg::mag_t NOISE_LIMIT = dsp_pkg::mag_t'(`NOISE_LIMIT);

    dsp_pkg::mag_t corr_mag [detector_pkg::NUM_LANES];
    dsp_pkg::mag_t energy_limit;
    detector_pkg::peak_vec_t peak;
    detector_pkg::nid2_t lane;
    logic single_peak;
    detector_pkg::count_t count_q [detector_pkg::NUM_LANES];

    assign corr_mag[0] = corr_mag_0_i;
    assign corr_mag[1] = corr_mag_1_i;
    assign corr_mag[2] = corr_mag_2_i;

    // ----------------------------------------
    // per-lane thresholds
    // ----------------------------------------

    always_comb begin
        energy_limit = energy_i >> `DETECTION_SHIFT;
        peak = '0;
        if (energy_valid_i && (mode_i != detector_pkg::PAUSE)) begin
            for (int l = 0; l < detector_pkg::NUM_LANES; l++) begin
                peak[l] = (corr_mag[l] > NOISE_LIMIT) && (corr_mag[l] > energy_limit);
            end
        end
    end

    // only a lone lane counts as a result
    always_comb begin
        single_peak = 1'b1;
        lane        = 2'd0;
        case (peak)
            3'b001: lane = 2'd0;
            3'b010: lane = 2'd1;
            3'b100: lane = 2'd2;
            default: single_peak = 1'b0;
        endcase
    end

    // ----------------------------------------
    // mode decision
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            nid2_o       <= '0;
            nid2_valid_o <= 1'b0;
        end else begin
            nid2_valid_o <= 1'b0;
            if (single_peak) begin
                case (mode_i)
                    detector_pkg::SEARCH: begin
                        nid2_o       <= lane;
                        nid2_valid_o <= 1'b1;
                    end
                    detector_pkg::FIND: begin
                        if (lane == requested_nid2_i) begin
                            nid2_o       <= lane;
                            nid2_valid_o <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // peak counters, PAUSE already masked in peak
    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            for (int l = 0; l < detector_pkg::NUM_LANES; l++) begin
                count_q[l] <= '0;
            end
        end else begin
            for (int l = 0; l < detector_pkg::NUM_LANES; l++) begin
                if (peak[l]) begin
                    count_q[l] <= count_q[l] + 1'b1;
                end
            end
        end
    end

    assign peak_count_0_o = count_q[0];
    assign peak_count_1_o = count_q[1];
    assign peak_count_2_o = count_q[2];

endmodule

/* rtl/energy_window.sv */
`timescale 1ns/1ps

`include "pss_params.svh"

module energy_window (
    input  logic             clk_i,
    input  logic             reset_int_n,
    input  dsp_pkg::sample_u sample_i,
    input  logic             sample_valid_i,
    output dsp_pkg::mag_t    energy_o,
    output logic             energy_valid_o
);

    localparam int EXT_W  = `SAMPLE_W + 1;
    localparam int FILL_W = $clog2(`PSS_LEN + 1);
    localparam logic [FILL_W-1:0] FILL_FULL = FILL_W'(`PSS_LEN);

    logic signed [EXT_W-1:0] i_ext;
    logic signed [EXT_W-1:0] q_ext;
    logic [EXT_W-1:0] i_abs;
    logic [EXT_W-1:0] q_abs;
    dsp_pkg::mag_t new_mag;

    // hist_q[0] leaves the window on the next strobe
    dsp_pkg::mag_t hist_q [`PSS_LEN];
    logic [FILL_W-1:0] fill_q;

    // |I| + |Q| of the incoming sample, -32768 still fits after extension
    always_comb begin
        i_ext   = EXT_W'(sample_i.iq.i);
        q_ext   = EXT_W'(sample_i.iq.q);
        i_abs   = (i_ext < 0) ? -i_ext : i_ext;
        q_abs   = (q_ext < 0) ? -q_ext : q_ext;
        new_mag = dsp_pkg::mag_t'(i_abs) + dsp_pkg::mag_t'(q_abs);
    end

    // ----------------------------------------
    // running sum over the window
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            for (int k = 0; k < `PSS_LEN; k++) begin
                hist_q[k] <= '0;
            end
            energy_o <= '0;
        end else if (sample_valid_i) begin
            for (int k = 0; k < `PSS_LEN - 1; k++) begin
                hist_q[k] <= hist_q[k+1];
            end
            hist_q[`PSS_LEN-1] <= new_mag;
            energy_o <= energy_o + new_mag - hist_q[0];
        end
    end

    // warm-up, valid from the strobe that fills the window
    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            fill_q         <= '0;
            energy_valid_o <= 1'b0;
        end else begin
            if (sample_valid_i && (fill_q != FILL_FULL)) begin
                fill_q <= fill_q + 1'b1;
            end
            energy_valid_o <= sample_valid_i && (fill_q >= FILL_FULL - 1'b1);
        end
    end

endmodule

/* rtl/pss_correlator.sv */
`timescale 1ns/1ps

`include "pss_params.svh"

module pss_correlator #(
    parameter int LANE = 0
) (
    input  logic             clk_i,
    input  logic             reset_int_n,
    input  dsp_pkg::sample_u sample_i,
    input  logic             sample_valid_i,
    output dsp_pkg::mag_t    corr_mag_o
);

    // one bit of growth per tap doubling plus sign
    localparam int SUM_W = `SAMPLE_W + $clog2(`PSS_LEN) + 1;
    localparam logic [`PSS_LEN-1:0] TAPS = detector_pkg::PSS_TAPS[LANE];

    // line_q[0] is the oldest sample
    dsp_pkg::sample_u line_q [`PSS_LEN];
    dsp_pkg::sample_u window [`PSS_LEN];

    logic signed [SUM_W-1:0] sum_re;
    logic signed [SUM_W-1:0] sum_im;
    logic [SUM_W-1:0] abs_re;
    logic [SUM_W-1:0] abs_im;

    // ----------------------------------------
    // window including the incoming sample
    // ----------------------------------------

    always_comb begin
        for (int k = 0; k < `PSS_LEN - 1; k++) begin
            window[k] = line_q[k+1];
        end
        window[`PSS_LEN-1] = sample_i;
    end

    // ----------------------------------------
    // +-1 correlation
    // ----------------------------------------

    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int k = 0; k < `PSS_LEN; k++) begin
            if (TAPS[k]) begin
                sum_re = sum_re - SUM_W'(window[k].iq.i);
                sum_im = sum_im - SUM_W'(window[k].iq.q);
            end else begin
                sum_re = sum_re + SUM_W'(window[k].iq.i);
                sum_im = sum_im + SUM_W'(window[k].iq.q);
            end
        end
        abs_re = sum_re[SUM_W-1] ? -sum_re : sum_re;
        abs_im = sum_im[SUM_W-1] ? -sum_im : sum_im;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            for (int k = 0; k < `PSS_LEN; k++) begin
                line_q[k].raw <= '0;
            end
            corr_mag_o <= '0;
        end else if (sample_valid_i) begin
            line_q     <= window;
            corr_mag_o <= dsp_pkg::mag_t'(abs_re) + dsp_pkg::mag_t'(abs_im);
        end
    end

endmodule

/* rtl/detector_pkg.sv */
`include "pss_params.svh"

package detector_pkg;

    parameter int NUM_LANES = 3;

    // ----------------------------------------
    // control and result types
    // ----------------------------------------

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } mode_e;

    typedef logic [1:0] nid2_t;

    // one detection bit per lane
    typedef logic [NUM_LANES-1:0] peak_vec_t;

    typedef logic [`COUNT_W-1:0] count_t;

    // ----------------------------------------
    // local sequences
    // ----------------------------------------

    // bit k set means tap k is -1, tap 0 meets the oldest sample
    // each row has eight -1 taps, pairwise distances 6 to 8
    // concatenation order is lane 2 first
    parameter logic [NUM_LANES-1:0][`PSS_LEN-1:0] PSS_TAPS = {
        16'h5E0D,
        16'h96C3,
        16'h3A59
    };

endpackage

/* rtl/dsp_pkg.sv */
`include "pss_params.svh"

package dsp_pkg;

    // ----------------------------------------
    // sample word
    // ----------------------------------------

    // Q sits in the upper half of the bus word, I in the lower half
    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] q;
        logic signed [`SAMPLE_W-1:0] i;
    } iq_t;

    // one bus word, seen either as raw bits or as I/Q
    typedef union packed {
        logic [2*`SAMPLE_W-1:0] raw;
        iq_t                    iq;
    } sample_u;

    // ----------------------------------------
    // magnitudes
    // ----------------------------------------

    // |re| + |im| of a correlation, or a window energy
    typedef logic [`MAG_W-1:0] mag_t;

endpackage

/* rtl/pss_params.svh */
`ifndef PSS_PARAMS_SVH
`define PSS_PARAMS_SVH

// ----------------------------------------
// window and datapath widths
// ----------------------------------------

// taps per sequence, also the energy window length
`define PSS_LEN 16
// width of I and of Q
`define SAMPLE_W 16
// correlation magnitude and energy sum
`define MAG_W 24

// ----------------------------------------
// detection limits
// ----------------------------------------

`define NOISE_LIMIT 64
`define DETECTION_SHIFT 1
`define COUNT_W 16

`endif
